//--- design/muldiv_pkg.sv
// shared definitions for the iterative multiply/divide subsystem
// function codes, response unit tags and the default operand width
package muldiv_pkg;

  // ----------------------------------------
  // operand width
  // ----------------------------------------

  // default operand width; results are twice this wide
  localparam int XLEN_DEFAULT = 32;

  // ----------------------------------------
  // request function codes
  // ----------------------------------------

  // mul   signed full-width product
  // div   signed divide, remainder up, quotient down
  // divu  unsigned divide, same result layout
  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_div  = 2'd1,
    fn_divu = 2'd2
  } fn_e;

  // ----------------------------------------
  // response tags
  // ----------------------------------------

  // names the unit that produced a response
  typedef enum logic {
    unit_mul = 1'b0,
    unit_div = 1'b1
  } unit_e;

endpackage

//--- design/int_div_iterative.sv
`timescale 1ns/1ps
// iterative restoring divider, one item at a time, val/rdy on both sides
// result holds the remainder in the upper half and the quotient in the lower half
module int_div_iterative #(
  parameter int XLEN = muldiv_pkg::XLEN_DEFAULT
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              req_val,
  output logic              req_rdy,
  input  muldiv_pkg::fn_e   req_fn,
  input  logic [XLEN-1:0]   req_a,
  input  logic [XLEN-1:0]   req_b,
  output logic              resp_val,
  input  logic              resp_rdy,
  output logic [2*XLEN-1:0] resp_result
);
  import muldiv_pkg::*;

  localparam int CNT_W = $clog2(XLEN);

  typedef enum logic [1:0] {st_idle, st_calc, st_fix, st_done} state_e;

  state_e            state;
  logic [CNT_W-1:0]  cnt;

  // remainder/quotient pair plus one guard bit for the sign of the difference
  logic [2*XLEN:0]   rq_reg;
  // divisor magnitude lined up under the remainder half
  logic [2*XLEN:0]   dvs_reg;
  logic              sign_a;
  logic              sign_b;
  logic              is_signed;
  logic [2*XLEN-1:0] result_reg;

  logic              req_fire;
  logic              resp_fire;
  logic              req_signed;
  logic [XLEN-1:0]   a_mag;
  logic [XLEN-1:0]   b_mag;
  logic [2*XLEN:0]   rq_shift;
  logic [2*XLEN:0]   rq_diff;
  logic [2*XLEN:0]   rq_next;
  logic [XLEN-1:0]   quot;
  logic [XLEN-1:0]   rem;
  logic [XLEN-1:0]   quot_fix;
  logic [XLEN-1:0]   rem_fix;

  // ----------------------------------------
  // handshake
  // ----------------------------------------

  assign req_rdy   = (state == st_idle);
  assign resp_val  = (state == st_done);
  assign req_fire  = req_val && req_rdy;
  assign resp_fire = resp_val && resp_rdy;

  // ----------------------------------------
  // operand magnitudes
  // ----------------------------------------

  // only fn_div treats the operands as two's complement
  assign req_signed = (req_fn == fn_div);
  assign a_mag      = (req_signed && req_a[XLEN-1]) ? -req_a : req_a;
  assign b_mag      = (req_signed && req_b[XLEN-1]) ? -req_b : req_b;

  // ----------------------------------------
  // one restoring step
  // ----------------------------------------

  assign rq_shift = rq_reg << 1;
  assign rq_diff  = rq_shift - dvs_reg;
  // negative difference means restore and shift in a zero
  assign rq_next  = rq_diff[2*XLEN] ? {rq_shift[2*XLEN:1], 1'b0}
                                    : {rq_diff[2*XLEN:1], 1'b1};

  // sign correction
  assign quot     = rq_reg[XLEN-1:0];
  assign rem      = rq_reg[2*XLEN-1:XLEN];
  // quotient follows the xor of the signs, remainder follows the dividend
  assign quot_fix = (is_signed && (sign_a ^ sign_b)) ? -quot : quot;
  assign rem_fix  = (is_signed && sign_a) ? -rem : rem;

  // ----------------------------------------
  // control FSM
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      cnt   <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_fire) begin
            state <= st_calc;
            cnt   <= CNT_W'(XLEN - 1);
          end
        end
        st_calc: begin
          // last iteration runs with the counter at zero
          if (cnt == '0) begin
            state <= st_fix;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        st_fix: begin
          state <= st_done;
        end
        st_done: begin
          // hold the result until the consumer takes it
          if (resp_fire) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // ----------------------------------------
  // datapath registers
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (req_fire) begin
      rq_reg    <= {{(XLEN + 1){1'b0}}, a_mag};
      dvs_reg   <= {1'b0, b_mag, {XLEN{1'b0}}};
      sign_a    <= req_a[XLEN-1];
      sign_b    <= req_b[XLEN-1];
      is_signed <= req_signed;
    end else if (state == st_calc) begin
      rq_reg <= rq_next;
    end
    if (state == st_fix) begin
      result_reg <= {rem_fix, quot_fix};
    end
  end

  assign resp_result = result_reg;

  // counter only counts down once an item is taken
  assert property (@(posedge clk) disable iff (reset)
    (state != st_idle) |=> (cnt <= $past(cnt)))
    else $error("divider iteration counter wrapped past zero");

endmodule

//--- design/int_mul_iterative.sv
`timescale 1ns/1ps
// iterative signed shift-add multiplier, one item at a time
// returns the full double-width two's-complement product
module int_mul_iterative #(
  parameter int XLEN = muldiv_pkg::XLEN_DEFAULT
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              req_val,
  output logic              req_rdy,
  input  logic [XLEN-1:0]   req_a,
  input  logic [XLEN-1:0]   req_b,
  output logic              resp_val,
  input  logic              resp_rdy,
  output logic [2*XLEN-1:0] resp_result
);

  localparam int CNT_W = $clog2(XLEN);

  typedef enum logic [1:0] {st_idle, st_calc, st_fix, st_done} state_e;

  state_e            state;
  logic [CNT_W-1:0]  cnt;

  // multiplicand moves left, multiplier moves right, one bit per cycle
  logic [2*XLEN-1:0] mcand;
  logic [XLEN-1:0]   mplier;
  logic [2*XLEN-1:0] prod;
  logic              neg;

  logic              req_fire;
  logic              resp_fire;
  logic [XLEN-1:0]   a_mag;
  logic [XLEN-1:0]   b_mag;

  assign req_rdy   = (state == st_idle);
  assign resp_val  = (state == st_done);
  assign req_fire  = req_val && req_rdy;
  assign resp_fire = resp_val && resp_rdy;

  assign a_mag = req_a[XLEN-1] ? -req_a : req_a;
  assign b_mag = req_b[XLEN-1] ? -req_b : req_b;

  // ----------------------------------------
  // control, same shape as the divider
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      cnt   <= '0;
    end else begin
      case (state)
        st_idle:  if (req_fire) begin
          state <= st_calc;
          cnt   <= CNT_W'(XLEN - 1);
        end
        st_calc:  if (cnt == '0) state <= st_fix;
                  else cnt <= cnt - 1'b1;
        st_fix:   state <= st_done;
        st_done:  if (resp_fire) state <= st_idle;
        default:  state <= st_idle;
      endcase
    end
  end

  // ----------------------------------------
  // shift-add datapath
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (req_fire) begin
      mcand  <= {{XLEN{1'b0}}, a_mag};
      mplier <= b_mag;
      prod   <= '0;
      neg    <= req_a[XLEN-1] ^ req_b[XLEN-1];
    end else if (state == st_calc) begin
      // add the shifted multiplicand for each set multiplier bit
      if (mplier[0]) begin
        prod <= prod + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end else if (state == st_fix && neg) begin
      prod <= -prod;
    end
  end

  assign resp_result = prod;

  // a finished product stays put until the consumer takes it
  assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result)))
    else $error("multiplier result changed while waiting for resp_rdy");

endmodule

//--- design/muldiv_issue.sv
`timescale 1ns/1ps
// routes requests to the multiplier or divider by function code
// and merges their responses round-robin onto one tagged port
module muldiv_issue #(
  parameter int XLEN = muldiv_pkg::XLEN_DEFAULT
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                req_val,
  output logic                req_rdy,
  input  muldiv_pkg::fn_e     req_fn,
  output logic                mul_req_val,
  input  logic                mul_req_rdy,
  output logic                div_req_val,
  input  logic                div_req_rdy,
  input  logic                mul_resp_val,
  output logic                mul_resp_rdy,
  input  logic [2*XLEN-1:0]   mul_resp_result,
  input  logic                div_resp_val,
  output logic                div_resp_rdy,
  input  logic [2*XLEN-1:0]   div_resp_result,
  output logic                resp_val,
  input  logic                resp_rdy,
  output logic [2*XLEN-1:0]   resp_result,
  output muldiv_pkg::unit_e   resp_unit
);
  import muldiv_pkg::*;

  logic  to_mul;
  unit_e last_grant;
  // a stalled response keeps its grant until it is taken
  logic  stall_q;
  unit_e stall_unit;
  unit_e rr_pick;
  unit_e sel_unit;
  logic  grant_mul;
  logic  grant_div;

  // ----------------------------------------
  // request steering
  // ----------------------------------------

  // anything that is not a multiply goes to the divider
  assign to_mul      = (req_fn == fn_mul);
  assign mul_req_val = req_val && to_mul;
  assign div_req_val = req_val && !to_mul;
  assign req_rdy     = to_mul ? mul_req_rdy : div_req_rdy;

  // ----------------------------------------
  // response arbitration
  // ----------------------------------------

  always_comb begin
    if (mul_resp_val && div_resp_val) begin
      rr_pick = (last_grant == unit_mul) ? unit_div : unit_mul;
    end else if (div_resp_val) begin
      rr_pick = unit_div;
    end else begin
      rr_pick = unit_mul;
    end
    sel_unit = stall_q ? stall_unit : rr_pick;
  end

  assign grant_mul    = mul_resp_val && (sel_unit == unit_mul);
  assign grant_div    = div_resp_val && (sel_unit == unit_div);
  assign resp_val     = grant_mul || grant_div;
  assign resp_unit    = sel_unit;
  assign resp_result  = grant_div ? div_resp_result : mul_resp_result;
  assign mul_resp_rdy = grant_mul && resp_rdy;
  assign div_resp_rdy = grant_div && resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      last_grant <= unit_div;
      stall_q    <= 1'b0;
      stall_unit <= unit_mul;
    end else begin
      stall_q    <= resp_val && !resp_rdy;
      stall_unit <= sel_unit;
      // moves only on an accepted response
      if (resp_val && resp_rdy) begin
        last_grant <= sel_unit;
      end
    end
  end

  // a locked grant never points at a unit that has nothing to send
  assert property (@(posedge clk) disable iff (reset)
    (mul_resp_val || div_resp_val) |-> resp_val)
    else $error("unit response waiting while the port shows none");

  // unit hold plus grant lock keep a stalled response steady
  assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result) && $stable(resp_unit)))
    else $error("response changed under back-pressure");

endmodule

//--- design/muldiv_unit.sv
`timescale 1ns/1ps
// top level of the multiply/divide subsystem
// one request port, one tagged response port, two units working side by side
module muldiv_unit #(
  parameter int XLEN = muldiv_pkg::XLEN_DEFAULT
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                req_val,
  output logic                req_rdy,
  input  muldiv_pkg::fn_e     req_fn,
  input  logic [XLEN-1:0]     req_a,
  input  logic [XLEN-1:0]     req_b,
  output logic                resp_val,
  input  logic                resp_rdy,
  output logic [2*XLEN-1:0]   resp_result,
  output muldiv_pkg::unit_e   resp_unit
);

  // ----------------------------------------
  // issue to unit wiring
  // ----------------------------------------

  logic              mul_req_val;
  logic              mul_req_rdy;
  logic              mul_resp_val;
  logic              mul_resp_rdy;
  logic [2*XLEN-1:0] mul_resp_result;
  logic              div_req_val;
  logic              div_req_rdy;
  logic              div_resp_val;
  logic              div_resp_rdy;
  logic [2*XLEN-1:0] div_resp_result;

  muldiv_issue #(.XLEN(XLEN)) u_issue (
    .clk, .reset,
    .req_val, .req_rdy, .req_fn,
    .mul_req_val, .mul_req_rdy, .div_req_val, .div_req_rdy,
    .mul_resp_val, .mul_resp_rdy, .mul_resp_result,
    .div_resp_val, .div_resp_rdy, .div_resp_result,
    .resp_val, .resp_rdy, .resp_result, .resp_unit
  );

  // operands fan out to both units, only the selected one sees req_val
  int_mul_iterative #(.XLEN(XLEN)) u_mul (
    .clk, .reset,
    .req_val(mul_req_val), .req_rdy(mul_req_rdy), .req_a, .req_b,
    .resp_val(mul_resp_val), .resp_rdy(mul_resp_rdy), .resp_result(mul_resp_result)
  );

  int_div_iterative #(.XLEN(XLEN)) u_div (
    .clk, .reset,
    .req_val(div_req_val), .req_rdy(div_req_rdy), .req_fn, .req_a, .req_b,
    .resp_val(div_resp_val), .resp_rdy(div_resp_rdy), .resp_result(div_resp_result)
  );

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps
// testbench clock and power-on reset
// reset drops on a falling edge once RESET_CYCLES rising edges have passed
module tb_clock_gen #(
  parameter real PERIOD_NS    = 4.0,
  parameter int  RESET_CYCLES = 10
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    // release away from the sampling edge
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

//--- testbench/tb_checker.sv
`timescale 1ns/1ps
// response checker for the multiply/divide testbench
// one expected queue per unit, filled on accepted requests, drained on accepted responses
module tb_checker #(
  parameter int XLEN = 32
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              req_val,
  input  logic              req_rdy,
  input  muldiv_pkg::fn_e   req_fn,
  input  logic [2*XLEN-1:0] exp_result,
  input  logic              resp_val,
  input  logic              resp_rdy,
  input  logic [2*XLEN-1:0] resp_result,
  input  muldiv_pkg::unit_e resp_unit,
  input  int                tb_errors,
  input  logic              end_check,
  output logic              drained,
  output logic              report_done,
  output int                total_errors
);
  import muldiv_pkg::*;

  // resp_val rises XLEN + 1 edges after the accept edge
  // and the first edge that can sample it comes one later
  localparam int MIN_LATENCY = XLEN + 2;

  logic [2*XLEN-1:0] mul_exp_q [$];
  logic [2*XLEN-1:0] div_exp_q [$];
  int                mul_stamp;
  int                div_stamp;
  logic              mul_busy;
  logic              div_busy;
  int                cycle;
  int                mismatch_count;
  int                other_count;
  int                overlap_cycles;
  int                stall_cycles;
  logic              seen_accept;
  // copy of a stalled response, compared on the next edge
  logic              held;
  logic [2*XLEN-1:0] held_result;
  unit_e             held_unit;

  task automatic take_response();
    logic [2*XLEN-1:0] expected;
    int                latency;
    logic              found;
    found    = 1'b0;
    expected = '0;
    latency  = 0;
    if (resp_unit == unit_mul && mul_exp_q.size() > 0) begin
      expected = mul_exp_q.pop_front();
      latency  = cycle - mul_stamp;
      mul_busy = 1'b0;
      found    = 1'b1;
    end else if (resp_unit == unit_div && div_exp_q.size() > 0) begin
      expected = div_exp_q.pop_front();
      latency  = cycle - div_stamp;
      div_busy = 1'b0;
      found    = 1'b1;
    end
    if (!found) begin
      other_count++;
      $display("[%0t] response tagged %s with no request outstanding", $time,
               resp_unit.name());
    end else begin
      if (resp_result !== expected) begin
        mismatch_count++;
        $display("mismatch at %0t: %s returned %h, expected %h", $time,
                 resp_unit.name(), resp_result, expected);
      end
      if (latency < MIN_LATENCY) begin
        other_count++;
        $display("[%0t] response came back after only %0d cycles", $time, latency);
      end
    end
  endtask

  task automatic take_request();
    if (req_fn == fn_mul) begin
      if (mul_busy) begin
        other_count++;
        $display("[%0t] multiplier accepted a request while still busy", $time);
      end
      mul_exp_q.push_back(exp_result);
      mul_stamp = cycle;
      mul_busy  = 1'b1;
    end else begin
      if (div_busy) begin
        other_count++;
        $display("[%0t] divider accepted a request while still busy", $time);
      end
      div_exp_q.push_back(exp_result);
      div_stamp = cycle;
      div_busy  = 1'b1;
    end
    seen_accept = 1'b1;
  endtask

  task automatic finish_report();
    if (mul_exp_q.size() != 0 || div_exp_q.size() != 0) begin
      other_count++;
      $display("%0d multiplier and %0d divider responses never arrived",
               mul_exp_q.size(), div_exp_q.size());
    end
    // the run has to have exercised overlap and back-pressure
    if (overlap_cycles == 0) begin
      other_count++;
      $display("multiplier and divider were never busy at the same time");
    end
    if (stall_cycles == 0) begin
      other_count++;
      $display("response port never saw back-pressure");
    end
    total_errors = mismatch_count + other_count + tb_errors;
    $display("error counts: %0d mismatches, %0d checker, %0d stimulus, %0d total",
             mismatch_count, other_count, tb_errors, total_errors);
    report_done = 1'b1;
  endtask

  // ----------------------------------------
  // per-edge watch of both ports
  // ----------------------------------------

  always @(posedge clk) begin
    if (reset) begin
      mul_exp_q.delete();
      div_exp_q.delete();
      mul_busy       = 1'b0;
      div_busy       = 1'b0;
      mul_stamp      = 0;
      div_stamp      = 0;
      cycle          = 0;
      mismatch_count = 0;
      other_count    = 0;
      overlap_cycles = 0;
      stall_cycles   = 0;
      seen_accept    = 1'b0;
      held           = 1'b0;
      held_result    = '0;
      held_unit      = unit_mul;
      drained        = 1'b1;
      report_done    = 1'b0;
      total_errors   = 0;
    end else begin
      cycle = cycle + 1;
      // quiet ports until the first request goes in
      if (!seen_accept && resp_val) begin
        other_count++;
        $display("[%0t] response valid before any request", $time);
      end
      if (!seen_accept && !req_rdy) begin
        other_count++;
        $display("[%0t] request port not ready with both units idle", $time);
      end
      if (held && (!resp_val || resp_result !== held_result || resp_unit !== held_unit)) begin
        mismatch_count++;
        $display("mismatch at %0t: response changed while stalled", $time);
      end
      held        = resp_val && !resp_rdy;
      held_result = resp_result;
      held_unit   = resp_unit;
      if (held) begin
        stall_cycles++;
      end
      // a unit in DONE is not ready, so the response goes first
      if (resp_val && resp_rdy) begin
        take_response();
      end
      if (req_val && req_rdy) begin
        take_request();
      end
      if (mul_busy && div_busy) begin
        overlap_cycles++;
      end
      drained = !mul_busy && !div_busy;
      if (end_check && !report_done) begin
        finish_report();
      end
    end
  end

endmodule

//--- testbench/tb_muldiv.sv
`timescale 1ns/1ps
// top testbench of the multiply/divide subsystem
// issues the cases file one request at a time and leaves the judging to the checker
module tb_muldiv;
  import muldiv_pkg::*;

  localparam int XLEN           = 32;
  localparam int REQ_TIMEOUT    = 300;
  localparam int DRAIN_TIMEOUT  = 400;
  localparam int RESET_TIMEOUT  = 50;
  localparam int REPORT_TIMEOUT = 10;
  // forced back-pressure window, in clock cycles from time zero
  localparam int HOLD_START     = 150;
  localparam int HOLD_END       = 230;

  logic              clk;
  logic              reset;
  logic              req_val;
  logic              req_rdy;
  fn_e               req_fn;
  logic [XLEN-1:0]   req_a;
  logic [XLEN-1:0]   req_b;
  logic              resp_val;
  logic              resp_rdy = 1'b0;
  logic [2*XLEN-1:0] resp_result;
  unit_e             resp_unit;
  logic [2*XLEN-1:0] exp_result;
  logic              end_check;
  logic              drained;
  logic              report_done;
  int                total_errors;
  int                tb_errors;
  logic              aborted;
  int                seed = 32'hb7bfbc00;
  int                cycle = 0;
  logic [31:0]       rnd_word;

  tb_clock_gen #(.PERIOD_NS(4.0), .RESET_CYCLES(10)) u_clock (.clk, .reset);

  muldiv_unit #(.XLEN(XLEN)) UUT (
    .clk, .reset,
    .req_val, .req_rdy, .req_fn, .req_a, .req_b,
    .resp_val, .resp_rdy, .resp_result, .resp_unit
  );

  tb_checker #(.XLEN(XLEN)) u_checker (
    .clk, .reset,
    .req_val, .req_rdy, .req_fn, .exp_result,
    .resp_val, .resp_rdy, .resp_result, .resp_unit,
    .tb_errors, .end_check, .drained, .report_done, .total_errors
  );

  // ----------------------------------------
  // response back-pressure
  // ----------------------------------------

  // ready about 70 percent of the time, held low through one long window
  always @(negedge clk) begin
    rnd_word = $random(seed);
    if (reset || (cycle >= HOLD_START && cycle < HOLD_END)) begin
      resp_rdy = 1'b0;
    end else begin
      resp_rdy = (rnd_word[6:0] < 7'd90);
    end
    cycle = cycle + 1;
  end

  task automatic wait_reset_release();
    int waited;
    waited = 0;
    // reset is still unknown at time zero
    while (reset !== 1'b0 && waited < RESET_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (reset !== 1'b0) begin
      tb_errors++;
      aborted = 1'b1;
      $display("reset was still high after %0d cycles", RESET_TIMEOUT);
    end
  endtask

  // present one case and hold it until an edge accepts it
  task automatic issue_case(input int idx, input logic [1:0] fn_raw,
                            input logic [XLEN-1:0] a_val, input logic [XLEN-1:0] b_val,
                            input logic [2*XLEN-1:0] exp_val);
    int   waited;
    logic accepted;
    @(negedge clk);
    req_val    = 1'b1;
    req_fn     = fn_e'(fn_raw);
    req_a      = a_val;
    req_b      = b_val;
    exp_result = exp_val;
    waited     = 0;
    accepted   = 1'b0;
    while (!accepted && waited < REQ_TIMEOUT) begin
      @(posedge clk);
      accepted = req_rdy;
      waited++;
    end
    if (!accepted) begin
      tb_errors++;
      aborted = 1'b1;
      $display("case %0d was not accepted within %0d cycles", idx, REQ_TIMEOUT);
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin : stimulus
    int                fd;
    int                code;
    int                n;
    int                num_cases;
    int                waited;
    string             line;
    logic [1:0]        fn_raw;
    logic [XLEN-1:0]   a_val;
    logic [XLEN-1:0]   b_val;
    logic [2*XLEN-1:0] exp_val;
    req_val    = 1'b0;
    req_fn     = fn_mul;
    req_a      = '0;
    req_b      = '0;
    exp_result = '0;
    end_check  = 1'b0;
    tb_errors  = 0;
    aborted    = 1'b0;
    num_cases  = 0;
    wait_reset_release();
    fd = $fopen("testbench/muldiv_cases.txt", "r");
    if (fd == 0) begin
      tb_errors++;
      aborted = 1'b1;
      $display("could not open the cases file");
    end
    // lines starting with # are comments
    while (!aborted && !$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line[0] != "#") begin
        n = $sscanf(line, "%h %h %h %h", fn_raw, a_val, b_val, exp_val);
        if (n == 4) begin
          issue_case(num_cases, fn_raw, a_val, b_val, exp_val);
          num_cases++;
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    @(negedge clk);
    req_val = 1'b0;
    if (!aborted && num_cases == 0) begin
      tb_errors++;
      $display("the cases file held no cases");
    end
    waited = 0;
    while (!drained && waited < DRAIN_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!drained) begin
      tb_errors++;
      $display("responses still outstanding after %0d cycles", DRAIN_TIMEOUT);
    end
    end_check = 1'b1;
    waited = 0;
    while (!report_done && waited < REPORT_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!report_done) begin
      $display("checker gave no report within %0d cycles", REPORT_TIMEOUT);
      $display("ERRORS FOUND");
    end else if (total_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- files.f
design/muldiv_pkg.sv
design/int_div_iterative.sv
design/int_mul_iterative.sv
design/muldiv_issue.sv
design/muldiv_unit.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/tb_muldiv.sv

//--- run_sim.sh
#!/bin/sh
# builds the multiply/divide testbench with Verilator, runs it into a log
# and passes only if the log holds the pass line

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG="$BUILD_DIR/sim.log"

if ! mkdir -p "$BUILD_DIR"; then
  echo "could not create $BUILD_DIR"
  exit 1
fi

if ! verilator --binary --assert --timescale 1ns/1ps \
    --top-module tb_muldiv -Mdir "$BUILD_DIR/obj_dir" -o tb_muldiv -f files.f; then
  echo "verilator build failed"
  exit 1
fi

if ! "$BUILD_DIR/obj_dir/tb_muldiv" > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation exited with a failing status"
  exit 1
fi

cat "$LOG"
if grep -qx "NO ERRORS" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1

//--- testbench/muldiv_cases.txt
# columns: fn a b expected, all hex; fn 0 mul, 1 signed div, 2 unsigned div
# expected is the 64-bit product, or remainder in the upper half and quotient in the lower
0 00000003 00000005 000000000000000F
2 FFFFFFFF 00000007 0000000324924924
0 FFFFFFFD 00000005 FFFFFFFFFFFFFFF1
2 00000005 00000009 0000000500000000
0 FFFFFFFD FFFFFFFB 000000000000000F
2 12345678 00000000 12345678FFFFFFFF
0 12345678 00010000 0000123456780000
2 000003E8 00000019 0000000000000028
0 80000000 80000000 4000000000000000
2 80000000 00000003 000000022AAAAAAA
0 80000000 00000001 FFFFFFFF80000000
1 00000064 00000007 000000020000000E
0 7FFFFFFF 7FFFFFFF 3FFFFFFF00000001
1 FFFFFF9C 00000007 FFFFFFFEFFFFFFF2
0 FFFFFFFF 7FFFFFFF FFFFFFFF80000001
1 00000064 FFFFFFF9 00000002FFFFFFF2
1 FFFFFF9C FFFFFFF9 FFFFFFFE0000000E
1 FFFFFFFB 00000000 FFFFFFFB00000001
1 00000007 00000000 00000007FFFFFFFF
1 80000000 00000001 0000000080000000
